/* dataMem.sv */
// Synchronous word memory, write in M and read data in W
// Array has no reset, contents are unknown until written
`timescale 1ns/1ps
`include "lsu_settings.svh"

module dataMem (
  input  logic              clk,
  input  logic              stall, // Blocks both read and write
  memReqIf.mem              req,   // Address and store data in M
  input  lsuOpPkg::rwCodeE  rw,    // Final operation after SC squash
  output lsuStagePkg::dataT rData  // Read word, valid in W
);
  import lsuStagePkg::*;

  dataT    mem [`LSU_MEM_WORDS]; // Word array
  wordAdrT wordAdr;              // Index into the array
  logic    wrEn, rdEn;

  //////////////////////////////////////////////////
  // Access enables
  //////////////////////////////////////////////////

  assign wordAdr = wordOf(req.adr);
  assign wrEn    = rw[0] & ~stall; // Write bit
  assign rdEn    = rw[1] & ~stall; // Read bit

  //////////////////////////////////////////////////
  // Array write and registered read
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wrEn) mem[wordAdr] <= req.wData;
  end

  // Read register holds between reads, so the W data stays put during stall
  always_ff @(posedge clk) begin
    if (rdEn) rData <= mem[wordAdr];
  end

endmodule

/* loadStoreUnit.sv */
// Load/store unit top, decode -> M -> W with a fixed 2-cycle latency
// A high stall freezes the whole pipeline and ignores new requests
`timescale 1ns/1ps

module loadStoreUnit (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 stall,    // Global pipeline hold
  input  logic                 reqValid,
  input  lsuOpPkg::lsuOpE      reqOp,
  input  lsuStagePkg::physAdrT reqAdr,   // Word aligned byte address
  input  lsuStagePkg::dataT    reqData,  // Store or SC data
  output logic                 rspValid,
  output lsuStagePkg::dataT    rspData,  // Load word, SC result or 0
  output logic                 scFail
);
  import lsuOpPkg::*;
  import lsuStagePkg::*;

  rwCodeE rwM;        // Memory operation after squash
  logic   squashScW;  // Failed SC in W
  dataT   rDataW;     // Memory read word in W

  memReqIf reqM ();   // Request held in M

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  opDecode decodeStage (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (stall),
    .reqValid (reqValid),
    .reqOp    (reqOp),
    .reqAdr   (reqAdr),
    .reqData  (reqData),
    .req      (reqM.src)
  );

  //////////////////////////////////////////////////
  // Memory stage
  //////////////////////////////////////////////////

  reservationUnit resvUnit (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .req       (reqM.resv),
    .rw        (rwM),
    .squashScW (squashScW)
  );

  dataMem memory (
    .clk   (clk),
    .stall (stall),
    .req   (reqM.mem),
    .rw    (rwM),
    .rData (rDataW)
  );

  //////////////////////////////////////////////////
  // Writeback
  //////////////////////////////////////////////////

  writebackStage wbStage (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .valid     (reqM.valid),
    .op        (reqM.op),
    .rData     (rDataW),
    .squashScW (squashScW),
    .rspValid  (rspValid),
    .rspData   (rspData),
    .scFail    (scFail)
  );

endmodule

/* loadStoreUnit_checker.sv */
// Assertions on the LSU response, bound into the writeback stage
// Only the W outputs are watched, stall is the global hold
`timescale 1ns/1ps

module loadStoreUnit_checker (
  input logic              clk,
  input logic              rstN,
  input logic              stall,
  input logic              rspValid,
  input lsuStagePkg::dataT rspData,
  input logic              scFail
);

  //////////////////////////////////////////////////
  // Response rules
  //////////////////////////////////////////////////

  // A failed SC is always a real response
  scFailNeedsValid: assert property (
    @(posedge clk) disable iff (!rstN) scFail |-> rspValid
  ) else $error("scFail high without rspValid");

  // No response while reset is held
  noRspInReset: assert property (
    @(posedge clk) !rstN |-> !rspValid
  ) else $error("rspValid high during reset");

  // A stalled edge changes nothing at the outputs
  holdInStall: assert property (
    @(posedge clk) disable iff (!rstN)
      $past(stall) |-> ($stable(rspValid) && $stable(rspData) && $stable(scFail))
  ) else $error("Outputs changed across a stalled edge");

endmodule

bind writebackStage loadStoreUnit_checker wbCheck (
  .clk       (clk),
  .rstN      (rstN),
  .stall     (stall),
  .rspValid  (rspValid),
  .rspData   (rspData),
  .scFail    (scFail)
);

/* loadStoreUnit_tb.sv */
// Testbench for the load/store unit. Loads only touch words that the table wrote first
// Each table row is one request, with optional stall cycles in front of it
`timescale 1ns/1ps
`include "lsu_settings.svh"

module loadStoreUnit_tb;
  import lsuOpPkg::*;
  import lsuStagePkg::*;

  localparam int MAX_ROWS = 32;
  localparam logic [31:0] LFSR_SEED = 32'h08801cc8;

  logic    clk, rstN, stall, reqValid;
  lsuOpE   reqOp;
  physAdrT reqAdr;
  dataT    reqData, rspData;
  logic    rspValid, scFail;

  // Stimulus table
  string   tName  [MAX_ROWS];
  lsuOpE   tOp    [MAX_ROWS];
  physAdrT tAdr   [MAX_ROWS];
  int      tStall [MAX_ROWS];  // Stall cycles before the row
  dataT    tData  [MAX_ROWS];
  logic    tValid [MAX_ROWS];  // reqValid driven with the row
  int      rowCount, totalStall;

  // Reference model state
  dataT          refMem [`LSU_MEM_WORDS];
  logic          resvValidRef;
  wordAdrT       resvAdrRef;
  logic          expValidM, expValidW, expFailM, expFailW;
  dataT          expDataM, expDataW;
  string         expNameM, expNameW;
  logic          prevStall;      // Stall seen by the last rising edge
  dataT          heldData;       // rspData at the previous check
  logic [31:0]   lfsrState;
  int            cycleCount, cycleLimit;

  loadStoreUnit UUT (
    .clk(clk), .rstN(rstN), .stall(stall), .reqValid(reqValid), .reqOp(reqOp),
    .reqAdr(reqAdr), .reqData(reqData), .rspValid(rspValid), .rspData(rspData),
    .scFail(scFail)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1, one bit per step
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawWord(output dataT w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsrState = lfsrNext(lfsrState);
      w = {w[30:0], lfsrState[0]};   // Take the new bit
    end
  endtask

  task automatic checkValue(string name, string what, logic [31:0] expected,
                            logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: %s expected %h actual %h", name, what, expected, actual);
      $display("Test failed");
      $fatal(1, "Response mismatch");
    end
  endtask

  task automatic addRow(string name, lsuOpE op, physAdrT adr, int stallCycles);
    tName[rowCount]  = name;
    tOp[rowCount]    = op;
    tAdr[rowCount]   = adr;
    tStall[rowCount] = stallCycles;
    tValid[rowCount] = 1'b1;
    drawWord(tData[rowCount]);         // Store or SC data, random for the rest
    totalStall = totalStall + stallCycles;
    rowCount++;
  endtask

  task automatic buildTable();
    addRow("store_a",       OP_STORE, 10'h010, 0);
    addRow("load_a",        OP_LOAD,  10'h010, 0);  // Back to back with the store
    addRow("store_b",       OP_STORE, 10'h020, 0);
    addRow("store_c",       OP_STORE, 10'h030, 0);
    addRow("load_b",        OP_LOAD,  10'h020, 0);
    addRow("load_c",        OP_LOAD,  10'h030, 0);
    addRow("lr_b",          OP_LR,    10'h020, 0);
    addRow("sc_b_ok",       OP_SC,    10'h020, 0);
    addRow("load_b_sc",     OP_LOAD,  10'h020, 0);  // Sees the SC data
    addRow("sc_again",      OP_SC,    10'h020, 0);  // Reservation already used
    addRow("load_b_kept",   OP_LOAD,  10'h020, 0);
    addRow("sc_no_resv",    OP_SC,    10'h030, 0);
    addRow("lr_c",          OP_LR,    10'h030, 0);
    addRow("sc_wrong_word", OP_SC,    10'h010, 0);
    addRow("load_a_kept",   OP_LOAD,  10'h010, 0);
    addRow("store_d",       OP_STORE, 10'h3fc, 0);
    addRow("lr_d",          OP_LR,    10'h3fc, 3);  // Stall with W and M both busy
    addRow("sc_d_ok",       OP_SC,    10'h3fc, 0);
    addRow("nop_gap",       OP_NOP,   10'h000, 0);
    addRow("load_d",        OP_LOAD,  10'h3fc, 2);
    addRow("idle_store",    OP_STORE, 10'h010, 0);  // reqValid low, must be dropped
    tValid[rowCount-1] = 1'b0;
    addRow("load_a_end",    OP_LOAD,  10'h010, 0);
    addRow("drain_0",       OP_NOP,   10'h000, 0);  // Flush the pipe
    addRow("drain_1",       OP_NOP,   10'h000, 0);
  endtask

  //////////////////////////////////////////////////
  // Reference model, one step per accepted request
  //////////////////////////////////////////////////

  task automatic modelRequest(input int i);
    wordAdrT w;
    w = tAdr[i][`LSU_PA_BITS-1:2];
    expValidW = expValidM;             // M moves to W
    expDataW  = expDataM;
    expFailW  = expFailM;
    expNameW  = expNameM;
    expNameM  = tName[i];
    expValidM = 1'b1;
    expFailM  = 1'b0;
    expDataM  = '0;
    case (tValid[i] ? tOp[i] : OP_NOP)  // A row without reqValid acts as a nop
      OP_LOAD:  expDataM = refMem[w];
      OP_STORE: refMem[w] = tData[i];  // Reservation untouched
      OP_LR: begin
        resvValidRef = 1'b1;
        resvAdrRef   = w;
        expDataM     = refMem[w];
      end
      OP_SC: begin
        if (resvValidRef && resvAdrRef == w) begin
          refMem[w] = tData[i];
        end else begin
          expDataM = 32'd1;            // Failure code
          expFailM = 1'b1;
        end
        resvValidRef = 1'b0;           // Pass or fail
      end
      default:  expValidM = 1'b0;      // Nop never responds
    endcase
  endtask

  task automatic checkOutputs();
    if (expValidW) begin
      checkValue(expNameW, "rspValid", 32'd1, 32'(rspValid));
      checkValue(expNameW, "rspData", expDataW, rspData);
      checkValue(expNameW, "scFail", 32'(expFailW), 32'(scFail));
    end else begin
      checkValue("idle", "rspValid", 32'd0, 32'(rspValid));
      checkValue("idle", "scFail", 32'd0, 32'(scFail));
    end
    if (prevStall) checkValue(expNameW, "rspData held in stall", heldData, rspData);
    heldData = rspData;
  endtask

  task automatic driveRow(input int i, input logic stallBit);
    stall     = stallBit;
    reqValid  = tValid[i];             // Nop rows still send a valid nop
    reqOp     = tOp[i];
    reqAdr    = tAdr[i];
    reqData   = tData[i];
    prevStall = stallBit;
  endtask

  //////////////////////////////////////////////////
  // Timeout
  //////////////////////////////////////////////////

  initial begin
    cycleCount = 0;
    wait (cycleLimit > 0);
    while (cycleCount <= cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run went past %0d clock cycles", cycleLimit);
    $display("Test failed");
    $fatal(1, "Timeout");
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rstN         = 1'b1;
    stall        = 1'b0;
    reqValid     = 1'b0;
    reqOp        = OP_NOP;
    reqAdr       = '0;
    reqData      = '0;
    lfsrState    = LFSR_SEED;
    resvValidRef = 1'b0;
    resvAdrRef   = '0;
    expValidM    = 1'b0;
    expValidW    = 1'b0;
    expFailM     = 1'b0;
    expFailW     = 1'b0;
    expDataM     = '0;
    expDataW     = '0;
    expNameM     = "idle";
    expNameW     = "idle";
    prevStall    = 1'b0;
    heldData     = '0;
    rowCount     = 0;
    totalStall   = 0;
    cycleLimit   = 0;
    buildTable();
    cycleLimit = rowCount + totalStall + 20;

    #1 rstN = 1'b0;                    // Clean falling edge on reset
    repeat (3) begin
      @(negedge clk);
      checkValue("reset", "rspValid", 32'd0, 32'(rspValid));
      checkValue("reset", "scFail", 32'd0, 32'(scFail));
    end
    rstN = 1'b1;

    for (int i = 0; i < rowCount; i++) begin
      for (int s = 0; s < tStall[i]; s++) begin
        @(negedge clk);
        checkOutputs();
        driveRow(i, 1'b1);             // Request must be ignored
      end
      @(negedge clk);
      checkOutputs();
      driveRow(i, 1'b0);
      modelRequest(i);
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* lsuOpPkg.sv */
// Request opcodes and memory operation codes of the LSU
// SC result on rspData is 0 for success and 1 for failure
package lsuOpPkg;

  //////////////////////////////////////////////////
  // Request opcode at the LSU input
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_NOP   = 3'd0,  // No access, never responds
    OP_LOAD  = 3'd1,  // Plain word load
    OP_STORE = 3'd2,  // Plain word store
    OP_LR    = 3'd3,  // Load reserved
    OP_SC    = 3'd4   // Store conditional
  } lsuOpE;

  // Memory operation code
  // Bit 1 is read, bit 0 is write
  typedef enum logic [1:0] {
    RW_NONE  = 2'b00,
    RW_WRITE = 2'b01,
    RW_READ  = 2'b10,
    RW_BOTH  = 2'b11  // Not produced by decode, kept for the encoding
  } rwCodeE;

  // Value returned on rspData by an SC
  localparam logic SC_SUCCESS = 1'b0;
  localparam logic SC_FAILURE = 1'b1;

endpackage

/* lsuStagePkg.sv */
// Address and data types shared by the pipeline stages
// Addresses are byte addresses, always word aligned
`include "lsu_settings.svh"

package lsuStagePkg;

  //////////////////////////////////////////////////
  // Addresses
  //////////////////////////////////////////////////

  typedef logic [`LSU_PA_BITS-1:0] physAdrT;  // Byte address
  typedef logic [`LSU_PA_BITS-3:0] wordAdrT;  // Byte address without low 2 bits

  //////////////////////////////////////////////////
  // Data
  //////////////////////////////////////////////////

  typedef logic [`LSU_DATA_BITS-1:0] dataT;   // One memory word

  // Drop the byte offset, misaligned addresses are not supported
  function automatic wordAdrT wordOf(physAdrT adr);
    return adr[`LSU_PA_BITS-1:2];
  endfunction

  // All-zero word, store response data
  localparam dataT DATA_ZERO = '0;

endpackage

/* lsu_settings.svh */
// Sizes for the load/store unit. Single hart, 32-bit words only
// LSU_MEM_WORDS must equal 2**(LSU_PA_BITS-2)
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

//////////////////////////////////////////////////
// Address and data widths
//////////////////////////////////////////////////

`define LSU_PA_BITS    10   // Physical byte address width
`define LSU_DATA_BITS  32   // One data word

//////////////////////////////////////////////////
// Data memory
//////////////////////////////////////////////////

`define LSU_MEM_WORDS  256  // Word count, covers the full address space

`endif

/* memReqIf.sv */
// One decoded request held in the memory stage
// No handshake, valid qualifies the whole bundle
`timescale 1ns/1ps

interface memReqIf;
  import lsuOpPkg::*;
  import lsuStagePkg::*;

  //////////////////////////////////////////////////
  // Request fields, registered by decode
  //////////////////////////////////////////////////

  logic    valid;   // Entry holds a real access
  lsuOpE   op;      // Original opcode, needed again in W
  rwCodeE  preRw;   // Read/write before SC squash
  logic    atomic;  // LR or SC
  physAdrT adr;     // Byte address
  dataT    wData;   // Store data

  // Decode stage drives the bundle
  modport src (
    output valid, op, preRw, atomic, adr, wData
  );

  // Reservation tracking needs the access kind and the address
  modport resv (
    input valid, preRw, atomic, adr
  );

  // Data memory only needs the location and the store data
  modport mem (
    input adr, wData
  );

endinterface

/* opDecode.sv */
// Decode stage, maps the opcode to read/write and atomic bits
// Unknown opcodes are treated like a nop and never respond
`timescale 1ns/1ps

module opDecode (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 stall,    // Global pipeline hold
  input  logic                 reqValid, // Request present this cycle
  input  lsuOpPkg::lsuOpE      reqOp,
  input  lsuStagePkg::physAdrT reqAdr,
  input  lsuStagePkg::dataT    reqData,
  memReqIf.src                 req       // Registered request in M
);
  import lsuOpPkg::*;

  rwCodeE rwD;     // Decoded read/write
  logic   atomicD; // LR or SC
  logic   memOpD;  // Opcode is a real access

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  always_comb begin
    rwD     = RW_NONE;
    atomicD = 1'b0;
    memOpD  = 1'b1;
    case (reqOp)
      OP_LOAD:  rwD = RW_READ;
      OP_STORE: rwD = RW_WRITE;
      OP_LR: begin
        rwD     = RW_READ;   // Reads like a load
        atomicD = 1'b1;
      end
      OP_SC: begin
        rwD     = RW_WRITE;  // Writes unless squashed in M
        atomicD = 1'b1;
      end
      default:  memOpD = 1'b0; // Nop and unused codes
    endcase
  end

  //////////////////////////////////////////////////
  // Decode to M register
  //////////////////////////////////////////////////

  // Valid bit, inputs ignored while stalled
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) req.valid <= 1'b0;
    else if (!stall) req.valid <= reqValid & memOpD;
  end

  // Payload only matters when valid is set
  always_ff @(posedge clk) begin
    if (!stall) begin
      req.op     <= reqOp;
      req.preRw  <= rwD;
      req.atomic <= atomicD;
      req.adr    <= reqAdr;
      req.wData  <= reqData;
    end
  end

endmodule

/* reservationUnit.sv */
// LR/SC reservation for a single hart
// Plain stores never break the reservation, only LR and SC touch it
`timescale 1ns/1ps

module reservationUnit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             stall,     // Freezes reservation and squash flag
  memReqIf.resv            req,       // Request in M
  output lsuOpPkg::rwCodeE rw,        // Final memory operation
  output logic             squashScW  // Failed SC, aligned to W
);
  import lsuOpPkg::*;
  import lsuStagePkg::*;

  wordAdrT resvAdr;    // Reserved word
  logic    resvValid;  // Reservation held
  logic    resvNext;   // Next value of resvValid
  logic    lrM, scM;   // Atomic kind in M
  logic    adrMatchM;  // SC hits the reservation
  logic    squashScM;  // SC must not write

  //////////////////////////////////////////////////
  // Classify the access in M
  //////////////////////////////////////////////////

  assign lrM = req.valid & req.atomic & req.preRw[1];
  assign scM = req.valid & req.atomic & req.preRw[0];

  // Only the word address is compared
  assign adrMatchM = resvValid & (wordOf(req.adr) == resvAdr);
  assign squashScM = scM & ~adrMatchM;

  // Invalid entries and failing SCs never reach the memory
  assign rw = (req.valid & ~squashScM) ? req.preRw : RW_NONE;

  always_comb begin
    if (lrM)      resvNext = 1'b1;      // LR sets it
    else if (scM) resvNext = 1'b0;      // Any SC clears it, pass or fail
    else          resvNext = resvValid; // Hold otherwise
  end

  //////////////////////////////////////////////////
  // Reservation and squash registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resvValid <= 1'b0;
      squashScW <= 1'b0;
    end else if (!stall) begin
      resvValid <= resvNext;
      squashScW <= squashScM; // Used by W only for an SC
    end
  end

  // Address meaningless while resvValid is low
  always_ff @(posedge clk) begin
    if (lrM && !stall) resvAdr <= wordOf(req.adr);
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator, pass is decided from the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f vlog.f --top-module loadStoreUnit_tb -o simLsu \
  || { echo "Verilator build failed"; exit 1; }

simOutput="$(./obj_dir/simLsu 2>&1)"
echo "$simOutput"

echo "$simOutput" | grep -q "^Test completed successfully$" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

/* vlog.f */
+incdir+.
lsuOpPkg.sv
lsuStagePkg.sv
memReqIf.sv
opDecode.sv
reservationUnit.sv
dataMem.sv
writebackStage.sv
loadStoreUnit.sv
loadStoreUnit_checker.sv
loadStoreUnit_tb.sv

/* writebackStage.sv */
// Writeback stage, forms the response from the W register
// Store responds with 0, SC with its result bit, nop never responds
`timescale 1ns/1ps
`include "lsu_settings.svh"

module writebackStage (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stall,     // Holds W, outputs stay stable
  input  logic              valid,     // Request valid in M
  input  lsuOpPkg::lsuOpE   op,        // Opcode in M
  input  lsuStagePkg::dataT rData,     // Memory word, already in W
  input  logic              squashScW, // SC failed, already in W
  output logic              rspValid,
  output lsuStagePkg::dataT rspData,
  output logic              scFail
);
  import lsuOpPkg::*;
  import lsuStagePkg::*;

  logic  validW; // Response pending
  lsuOpE opW;    // Kind of the W request
  logic  isScW;

  //////////////////////////////////////////////////
  // M to W register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validW <= 1'b0;
      opW    <= OP_NOP;
    end else if (!stall) begin
      validW <= valid;
      opW    <= op;
    end
  end

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////

  assign isScW    = validW & (opW == OP_SC);
  assign rspValid = validW;
  assign scFail   = isScW & squashScW; // Squash flag alone is stale for non-SC

  always_comb begin
    case (opW)
      OP_LOAD, OP_LR: rspData = rData;
      OP_SC:          rspData = {{(`LSU_DATA_BITS-1){1'b0}},
                                 squashScW ? SC_FAILURE : SC_SUCCESS};
      default:        rspData = DATA_ZERO; // Store, and nothing pending
    endcase
  end

endmodule
